//--- sim.f
mem_pkg.sv
mem_array.sv
instr_fetch.sv
data_store.sv
data_load.sv
mem_subsys.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the closing pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_mem_subsys -o sim_mem_subsys \
    && ./obj_dir/sim_mem_subsys | tee /dev/stderr | grep -q "^Done: no errors$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam int                tb_words = 64;
    localparam logic [xlen_p-1:0] tb_base  = 64'h8000_0000;

    localparam logic [1:0] fill_rand = 2'd0;
    localparam logic [1:0] fill_hi   = 2'd1; // Top bit of every byte set.
    localparam logic [1:0] fill_lo   = 2'd2; // Top bit of every byte clear.

    typedef struct packed {
        logic        fetch;
        logic [63:0] pc;
        logic        en;
        mem_op_e     op;
        logic [63:0] addr;
        logic [1:0]  fill;
        logic [63:0] wdata;
        logic        i_valid;
        logic        i_error;
        logic [31:0] instr;
        logic        d_valid;
        logic        d_error;
        logic [63:0] rdata;
    } row_t;

    logic      clk;
    logic      arst_n;
    logic      fetch_en;
    logic [63:0] pc;
    imem_rsp_t imem_rsp;
    dmem_req_t dmem_req;
    dmem_rsp_t dmem_rsp;

    row_t        rows [$];
    logic [63:0] ref_mem [tb_words];
    logic [31:0] rng_state = 32'h48db;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    mem_subsys #(
        .mem_words (tb_words),
        .base_addr (tb_base)
    ) dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .fetch_en (fetch_en),
        .pc       (pc),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the table did not finish within %0d cycles.", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [63:0] make_data(input logic [1:0] fill);
        logic [63:0] d;
        d[63:32] = xorshift32();
        d[31:0]  = xorshift32();
        if (fill == fill_hi) d = d | 64'h8080_8080_8080_8080;
        else if (fill == fill_lo) d = d & 64'h7f7f_7f7f_7f7f_7f7f;
        return d;
    endfunction

    function automatic logic [63:0] word_addr(input int w, input int off);
        return tb_base + 64'(w * 8 + off);
    endfunction

    function automatic logic out_of_range(input logic [63:0] a);
        return (a < tb_base) || (a >= tb_base + 64'(tb_words * 8));
    endfunction

    function automatic int word_index(input logic [63:0] a);
        return int'((a - tb_base) >> 3);
    endfunction

    function automatic int access_bytes(input mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    function automatic logic writes_memory(input mem_op_e op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw) || (op == op_sd);
    endfunction

    function automatic logic sign_extends(input mem_op_e op);
        return (op == op_lb) || (op == op_lh) || (op == op_lw);
    endfunction

    task automatic add_row(input logic fetch, input logic [63:0] fpc, input logic en,
                           input mem_op_e op, input logic [63:0] addr, input logic [1:0] fill);
        row_t r;
        r       = '0;
        r.fetch = fetch;
        r.pc    = fpc;
        r.en    = en;
        r.op    = op;
        r.addr  = addr;
        r.fill  = fill;
        rows.push_back(r);
    endtask

    task automatic add_idle();
        add_row(1'b0, 64'h0, 1'b0, op_ld, 64'h0, fill_rand);
    endtask

    task automatic build_table();
        mem_op_e store_ops [3] = '{op_sh, op_sw, op_sd};
        mem_op_e load_ops [6] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu};
        add_idle();
        add_idle();
        // Words 0 and 3 hold the clear and set top-bit patterns for the load checks.
        add_row(1'b0, 64'h0, 1'b1, op_sd, word_addr(0, 0), fill_lo);
        add_row(1'b0, 64'h0, 1'b1, op_sd, word_addr(1, 0), fill_rand);
        add_row(1'b0, 64'h0, 1'b1, op_sd, word_addr(2, 0), fill_rand);
        add_row(1'b0, 64'h0, 1'b1, op_sd, word_addr(3, 0), fill_hi);
        add_row(1'b0, 64'h0, 1'b1, op_ld, word_addr(0, 0), fill_rand);
        add_row(1'b0, 64'h0, 1'b1, op_ld, word_addr(3, 0), fill_rand);
        add_idle();
        for (int off = 0; off < 8; off++) begin
            add_row(1'b0, 64'h0, 1'b1, op_sb, word_addr(1, off), fill_rand);
            add_row(1'b0, 64'h0, 1'b1, op_ld, word_addr(1, 0), fill_rand);
        end
        // Halves, words and doublewords at odd offsets fold down to their natural lanes.
        for (int off = 0; off < 8; off++) begin
            for (int k = 0; k < 3; k++) begin
                add_row(1'b0, 64'h0, 1'b1, store_ops[k], word_addr(2, off), fill_rand);
                add_row(1'b0, 64'h0, 1'b1, op_ld, word_addr(2, 0), fill_rand);
            end
        end
        // Loads alternate between the set and clear words while fetches read word 2.
        for (int off = 0; off < 8; off++) begin
            for (int k = 0; k < 6; k++) begin
                add_row(1'b1, word_addr(2, 4 * ((off + k) % 2)), 1'b1, load_ops[k],
                        word_addr((((off + k) % 2) == 1) ? 0 : 3, off), fill_rand);
            end
        end
        add_row(1'b1, word_addr(2, 2), 1'b0, op_ld, 64'h0, fill_rand);
        add_row(1'b1, word_addr(2, 1), 1'b0, op_ld, 64'h0, fill_rand);
        add_row(1'b1, word_addr(2, 0), 1'b0, op_ld, 64'h0, fill_rand);
        add_idle();
        add_row(1'b1, tb_base - 64'd4, 1'b1, op_ld, tb_base - 64'd8, fill_rand);
        add_row(1'b1, word_addr(tb_words, 0), 1'b1, op_lw, word_addr(tb_words, 4), fill_rand);
        // These three would land on word 0 if the upper offset bits were ignored.
        add_row(1'b0, 64'h0, 1'b1, op_sb, tb_base - 64'(tb_words * 8), fill_rand);
        add_row(1'b0, 64'h0, 1'b1, op_sd, word_addr(tb_words, 0), fill_rand);
        add_row(1'b0, 64'h0, 1'b1, op_sw, word_addr(2 * tb_words, 0), fill_rand);
        add_row(1'b0, 64'h0, 1'b1, op_ld, word_addr(0, 0), fill_rand);
        add_row(1'b1, word_addr(2, 0), 1'b1, op_sd, word_addr(2, 0), fill_rand);
        add_row(1'b1, word_addr(2, 0), 1'b0, op_ld, 64'h0, fill_rand);
        add_row(1'b1, word_addr(2, 4), 1'b0, op_ld, 64'h0, fill_rand);
        add_idle();
    endtask

    // Walks the table in order and fills in store data and expected responses.
    task automatic predict_table();
        row_t        r;
        logic [63:0] w;
        logic [63:0] value;
        logic [63:0] mask;
        int          n;
        int          base;
        int          idx;
        for (int i = 0; i < rows.size(); i++) begin
            r       = rows[i];
            r.wdata = (r.en && writes_memory(r.op)) ? make_data(r.fill) : 64'h0;
            r.i_valid = r.fetch;
            r.i_error = r.fetch && (out_of_range(r.pc) || (r.pc[1:0] != 2'b00));
            r.instr   = 32'h0;
            if (r.fetch && !r.i_error) begin
                w       = ref_mem[word_index(r.pc)]; // Read before this row's store.
                r.instr = r.pc[2] ? w[63:32] : w[31:0];
            end
            r.d_valid = r.en;
            r.d_error = r.en && out_of_range(r.addr);
            r.rdata   = 64'h0;
            if (r.en && !r.d_error) begin
                n    = access_bytes(r.op);
                base = int'(r.addr[2:0]) & ~(n - 1);
                idx  = word_index(r.addr);
                if (writes_memory(r.op)) begin
                    for (int b = 0; b < n; b++) begin
                        ref_mem[idx][(base + b) * 8 +: 8] = r.wdata[b * 8 +: 8];
                    end
                end else begin
                    value = ref_mem[idx] >> (base * 8);
                    if (n < 8) begin
                        mask  = (64'h1 << (n * 8)) - 64'h1;
                        value = value & mask;
                        if (sign_extends(r.op) && value[n * 8 - 1]) value = value | ~mask;
                    end
                    r.rdata = value;
                end
            end
            rows[i] = r;
        end
    endtask

    task automatic check_value(input string name, input int row,
                               input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED row %0d %s: got %h, expected %h", row, name, got, exp);
        end
    endtask

    task automatic check_row(input int i);
        row_t r;
        r = rows[i];
        check_value("imem_rsp.valid", i, 64'(imem_rsp.valid), 64'(r.i_valid));
        check_value("imem_rsp.error", i, 64'(imem_rsp.error), 64'(r.i_error));
        if (r.i_valid) check_value("imem_rsp.instr", i, 64'(imem_rsp.instr), 64'(r.instr));
        check_value("dmem_rsp.valid", i, 64'(dmem_rsp.valid), 64'(r.d_valid));
        check_value("dmem_rsp.error", i, 64'(dmem_rsp.error), 64'(r.d_error));
        if (r.d_valid) check_value("dmem_rsp.rdata", i, dmem_rsp.rdata, r.rdata);
    endtask

    task automatic drive_row(input row_t r);
        fetch_en       = r.fetch;
        pc             = r.pc;
        dmem_req.en    = r.en;
        dmem_req.op    = r.op;
        dmem_req.addr  = r.addr;
        dmem_req.wdata = r.wdata;
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        fetch_en = 1'b0;
        pc       = 64'h0;
        dmem_req = '0;
        build_table();
        predict_table();
        cycle_limit = 10 + 2 * rows.size() + 20;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        // Each response is checked on the falling edge after the next rising edge.
        for (int i = 0; i <= rows.size(); i++) begin
            @(negedge clk);
            if (i > 0) check_row(i - 1);
            if (i < rows.size()) drive_row(rows[i]);
            else drive_row('0);
        end
        $display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
        if (errors == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys import mem_pkg::*; #(
    parameter int unsigned       mem_words = default_mem_words_p,
    parameter logic [xlen_p-1:0] base_addr = default_base_addr_p
) (
    input  wire logic              clk,
    input  wire logic              arst_n,

    input  wire logic              fetch_en,
    input  wire logic [xlen_p-1:0] pc,
    output imem_rsp_t              imem_rsp,

    input  dmem_req_t              dmem_req,
    output dmem_rsp_t              dmem_rsp
);

    logic              f_en;
    logic [xlen_p-1:0] f_addr;
    logic [xlen_p-1:0] f_data;
    logic              f_oor;

    logic              d_en;
    logic              d_we;
    logic [7:0]        d_be;
    logic [xlen_p-1:0] d_addr;
    logic [xlen_p-1:0] d_wdata;
    logic [xlen_p-1:0] d_data;
    logic              d_oor;

    instr_fetch u_instr_fetch (
        .clk      (clk),
        .arst_n   (arst_n),
        .fetch_en (fetch_en),
        .pc       (pc),
        .f_en     (f_en),
        .f_addr   (f_addr),
        .f_data   (f_data),
        .f_oor    (f_oor),
        .imem_rsp (imem_rsp)
    );

    data_store u_data_store (
        .dmem_req (dmem_req),
        .d_en     (d_en),
        .d_we     (d_we),
        .d_be     (d_be),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata)
    );

    data_load u_data_load (
        .clk      (clk),
        .arst_n   (arst_n),
        .dmem_req (dmem_req),
        .d_data   (d_data),
        .d_oor    (d_oor),
        .dmem_rsp (dmem_rsp)
    );

    mem_array #(
        .mem_words (mem_words),
        .base_addr (base_addr)
    ) u_mem_array (
        .clk     (clk),
        .arst_n  (arst_n),
        .f_en    (f_en),
        .f_addr  (f_addr),
        .f_data  (f_data),
        .f_oor   (f_oor),
        .d_en    (d_en),
        .d_we    (d_we),
        .d_be    (d_be),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_data  (d_data),
        .d_oor   (d_oor)
    );

endmodule

`default_nettype wire

//--- data_load.sv
`timescale 1ns/1ps
`default_nettype none

module data_load import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  dmem_req_t              dmem_req,

    input  wire logic [xlen_p-1:0] d_data,
    input  wire logic              d_oor,

    output dmem_rsp_t              dmem_rsp
);

    logic       valid_q;
    mem_op_e    op_q;
    logic [2:0] off_q;

    logic [7:0]        lane_b;
    logic [15:0]       lane_h;
    logic [31:0]       lane_w;
    logic [xlen_p-1:0] ext_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dmem_req.en;
        end
    end

    // Op and lane travel with the array read so both line up next cycle.
    always_ff @(posedge clk) begin
        if (dmem_req.en) begin
            op_q  <= dmem_req.op;
            off_q <= dmem_req.addr[2:0];
        end
    end

    assign lane_b = d_data[{off_q, 3'b000} +: 8];
    assign lane_h = d_data[{off_q[2:1], 4'b0000} +: 16];
    assign lane_w = d_data[{off_q[2], 5'b00000} +: 32];

    always_comb begin
        case (op_q)
            op_lb:   ext_data = {{56{lane_b[7]}}, lane_b};
            op_lbu:  ext_data = {56'h0, lane_b};
            op_lh:   ext_data = {{48{lane_h[15]}}, lane_h};
            op_lhu:  ext_data = {48'h0, lane_h};
            op_lw:   ext_data = {{32{lane_w[31]}}, lane_w};
            op_lwu:  ext_data = {32'h0, lane_w};
            op_ld:   ext_data = d_data;
            default: ext_data = '0; // Stores return no data.
        endcase
    end

    always_comb begin
        dmem_rsp.valid = valid_q;
        dmem_rsp.error = valid_q && d_oor;
        dmem_rsp.rdata = dmem_rsp.error ? '0 : ext_data;
    end

endmodule

`default_nettype wire

//--- data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store import mem_pkg::*; (
    input  dmem_req_t              dmem_req,

    output logic                   d_en,
    output logic                   d_we,
    output logic      [7:0]        d_be,
    output logic      [xlen_p-1:0] d_addr,
    output logic      [xlen_p-1:0] d_wdata
);

    logic [2:0] lane;

    assign lane   = dmem_req.addr[2:0];
    assign d_en   = dmem_req.en;
    assign d_we   = dmem_req.en && is_store(dmem_req.op);
    assign d_addr = dmem_req.addr;

    // Misaligned halves and words fold down to their natural lanes.
    always_comb begin
        case (dmem_req.op)
            op_sb: begin
                d_be    = 8'b0000_0001 << lane;
                d_wdata = {8{dmem_req.wdata[7:0]}};
            end
            op_sh: begin
                d_be    = 8'b0000_0011 << {lane[2:1], 1'b0};
                d_wdata = {4{dmem_req.wdata[15:0]}};
            end
            op_sw: begin
                d_be    = 8'b0000_1111 << {lane[2], 2'b00};
                d_wdata = {2{dmem_req.wdata[31:0]}};
            end
            op_sd: begin
                d_be    = 8'hff;
                d_wdata = dmem_req.wdata;
            end
            default: begin
                d_be    = 8'h00; // Loads write nothing.
                d_wdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              fetch_en,
    input  wire logic [xlen_p-1:0] pc,

    output logic                   f_en,
    output logic      [xlen_p-1:0] f_addr,
    input  wire logic [xlen_p-1:0] f_data,
    input  wire logic              f_oor,

    output imem_rsp_t              imem_rsp
);

    logic valid_q;
    logic hi_q;   // pc[2] of the request in flight.
    logic mis_q;

    assign f_en   = fetch_en;
    assign f_addr = {pc[xlen_p-1:3], 3'b000};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_en;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            hi_q  <= pc[2];
            mis_q <= (pc[1:0] != 2'b00);
        end
    end

    always_comb begin
        imem_rsp.valid = valid_q;
        imem_rsp.error = valid_q && (mis_q || f_oor);
        if (imem_rsp.error) imem_rsp.instr = '0;
        else                imem_rsp.instr = hi_q ? f_data[63:32] : f_data[31:0];
    end

endmodule

`default_nettype wire

//--- mem_array.sv
`timescale 1ns/1ps
`default_nettype none

module mem_array import mem_pkg::*; #(
    parameter int unsigned       mem_words = default_mem_words_p,
    parameter logic [xlen_p-1:0] base_addr = default_base_addr_p
) (
    input  wire logic              clk,
    input  wire logic              arst_n,

    input  wire logic              f_en,
    input  wire logic [xlen_p-1:0] f_addr,
    output logic      [xlen_p-1:0] f_data,
    output logic                   f_oor,

    input  wire logic              d_en,
    input  wire logic              d_we,
    input  wire logic [7:0]        d_be,
    input  wire logic [xlen_p-1:0] d_addr,
    input  wire logic [xlen_p-1:0] d_wdata,
    output logic      [xlen_p-1:0] d_data,
    output logic                   d_oor
);

    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
    localparam logic [xlen_p-1:0] mem_bytes = xlen_p'(mem_words) << 3;

    logic [xlen_p-1:0] words [mem_words];

    logic [xlen_p-1:0] f_off;
    logic [xlen_p-1:0] d_off;
    logic              f_in_range;
    logic              d_in_range;
    logic [idx_w-1:0]  f_idx;
    logic [idx_w-1:0]  d_idx;

    // An address below base_addr wraps to a large offset and fails the compare.
    assign f_off      = f_addr - base_addr;
    assign d_off      = d_addr - base_addr;
    assign f_in_range = (f_off < mem_bytes);
    assign d_in_range = (d_off < mem_bytes);
    assign f_idx      = f_off[idx_w+2:3];
    assign d_idx      = d_off[idx_w+2:3];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            f_oor <= 1'b0;
            d_oor <= 1'b0;
        end else begin
            if (f_en) begin
                f_oor <= !f_in_range;
            end
            if (d_en) begin
                d_oor <= !d_in_range;
            end
        end
    end

    // Reads take the word before any write in the same cycle.
    always_ff @(posedge clk) begin
        if (f_en) begin
            f_data <= f_in_range ? words[f_idx] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (d_en) begin
            d_data <= d_in_range ? words[d_idx] : '0;
            if (d_we && d_in_range) begin
                for (int b = 0; b < 8; b++) begin
                    if (d_be[b]) begin
                        words[d_idx][b*8 +: 8] <= d_wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int xlen_p = 64;

    // Defaults used by the top level when no override is given.
    localparam int unsigned default_mem_words_p = 1024;
    localparam logic [xlen_p-1:0] default_base_addr_p = 64'h8000_0000;

    // Bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the access size.
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_ld  = 4'b0011,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_lwu = 4'b0110,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010,
        op_sd  = 4'b1011
    } mem_op_e;

    typedef struct packed {
        logic              en;
        mem_op_e           op;
        logic [xlen_p-1:0] addr;
        logic [xlen_p-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic              valid;
        logic              error;
        logic [xlen_p-1:0] rdata;
    } dmem_rsp_t;

    typedef struct packed {
        logic        valid;
        logic        error;
        logic [31:0] instr;
    } imem_rsp_t;

    function automatic logic is_store(mem_op_e op);
        return op[3];
    endfunction

endpackage

`default_nettype wire
